/* hdl/serial_pkg.sv */
// Serial line constants referenced by scoped name from the UART, key and top-level logic
package serial_pkg;

  // ====================
  // Character format
  // ====================

  // Data bits per character sent LSB first on the line
  localparam int DATA_BITS = 8;

  // ====================
  // Line rate defaults
  // ====================

  // Board oscillator
  localparam int DEFAULT_CLK_FREQ = 50_000_000;
  // Host side rate
  localparam int DEFAULT_BAUD = 115_200;

  // Flops in every asynchronous input synchronizer
  localparam int SYNC_STAGES = 2;

endpackage

/* hdl/frame_pkg.sv */
// Frame buffer types and defaults referenced by scoped name from the buffer datapath
package frame_pkg;

  // ====================
  // Buffer contents
  // ====================

  // One resized image byte as stored in the buffer
  typedef logic [7:0] pixel_t;

  // Current image number written from the serial line in select mode
  typedef logic [7:0] img_sel_t;

  // ====================
  // Sizing
  // ====================

  // Entries in the on-chip buffer
  localparam int DEFAULT_DEPTH = 1024;

endpackage

/* hdl/frame_mem_if.sv */
// Write and read ports of the frame buffer shared by loader, RAM and playback controller
`timescale 1ns/1ps

interface frame_mem_if #(
  parameter int BUF_DEPTH = frame_pkg::DEFAULT_DEPTH
);

  localparam int ADDR_W = $clog2(BUF_DEPTH);

  // Write side takes one byte per cycle
  logic               wr_en;
  logic [ADDR_W-1:0]  wr_addr;
  frame_pkg::pixel_t  wr_data;

  // Read side returns data one cycle after the address
  logic [ADDR_W-1:0]  rd_addr;
  frame_pkg::pixel_t  rd_data;

  modport writer (output wr_en, output wr_addr, output wr_data);

  modport reader (output rd_addr, input rd_data);

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

/* hdl/uart_rx.sv */
// Serial receiver; synchronizes the line and strobes each recovered byte at its stop bit
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = serial_pkg::DEFAULT_CLK_FREQ / serial_pkg::DEFAULT_BAUD
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              rxd,
  output frame_pkg::pixel_t rx_data,
  output logic              rx_valid
);

  localparam int SYNC_N = serial_pkg::SYNC_STAGES;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(serial_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(serial_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t          state;
  logic [SYNC_N:0]    rxd_sync;
  logic               rxd_s;
  logic               rxd_fall;
  logic [CNT_W-1:0]   clk_cnt;
  logic [IDX_W-1:0]   bit_idx;

  // Extra top flop holds the previous synchronized level for edge detect
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_sync <= '1;
    end else begin
      rxd_sync <= {rxd_sync[SYNC_N-1:0], rxd};
    end
  end

  assign rxd_s    = rxd_sync[SYNC_N-1];
  assign rxd_fall = rxd_sync[SYNC_N] & ~rxd_s;

  // ====================
  // Bit timing FSM
  // ====================

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (rxd_fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Glitch shorter than half a bit goes back to idle
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            state   <= rxd_s ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_LAST) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // Framing error drops the byte
          if (clk_cnt == BIT_LAST) begin
            clk_cnt  <= '0;
            state    <= RX_IDLE;
            rx_valid <= rxd_s;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits shift in from the top since the LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state == RX_DATA && clk_cnt == BIT_LAST) begin
      rx_data <= {rxd_s, rx_data[serial_pkg::DATA_BITS-1:1]};
    end
  end

endmodule

/* hdl/frame_loader.sv */
// Routes each received byte to the image select register or into the frame buffer
`timescale 1ns/1ps

module frame_loader #(
  parameter int BUF_DEPTH = frame_pkg::DEFAULT_DEPTH
) (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  frame_pkg::pixel_t   rx_data,
  input  logic                rx_valid,
  input  logic                sw_load,
  frame_mem_if.writer         mem,
  output frame_pkg::img_sel_t img_sel
);

  localparam int ADDR_W = $clog2(BUF_DEPTH);
  localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(BUF_DEPTH - 1);

  logic              sw_load_q;
  logic              load_entry;
  logic              do_write;
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] cur_addr;

  // A byte landing on the same cycle as load entry goes to address 0
  assign load_entry = sw_load & ~sw_load_q;
  assign cur_addr   = load_entry ? '0 : wr_ptr;
  assign do_write   = rx_valid & sw_load;

  assign mem.wr_en   = do_write;
  assign mem.wr_addr = cur_addr;
  assign mem.wr_data = rx_data;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      sw_load_q <= 1'b0;
      wr_ptr    <= '0;
    end else begin
      sw_load_q <= sw_load;
      if (do_write) begin
        wr_ptr <= (cur_addr == ADDR_LAST) ? '0 : cur_addr + 1'b1;
      end else if (load_entry) begin
        wr_ptr <= '0;
      end
    end
  end

  // Select mode
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      img_sel <= '0;
    end else if (rx_valid && !sw_load) begin
      img_sel <= frame_pkg::img_sel_t'(rx_data);
    end
  end

endmodule

/* hdl/frame_ram.sv */
// On-chip frame buffer with one write port and one registered read port
`timescale 1ns/1ps

module frame_ram #(
  parameter int BUF_DEPTH = frame_pkg::DEFAULT_DEPTH
) (
  input  logic     CLOCK_50,
  frame_mem_if.mem mem
);

  frame_pkg::pixel_t ram [BUF_DEPTH];

  // ====================
  // Write port
  // ====================

  always_ff @(posedge CLOCK_50) begin
    if (mem.wr_en) begin
      ram[mem.wr_addr] <= mem.wr_data;
    end
  end

  // ====================
  // Read port
  // ====================

  // Old data on a same-address collision
  always_ff @(posedge CLOCK_50) begin
    mem.rd_data <= ram[mem.rd_addr];
  end

endmodule

/* hdl/playback_ctrl.sv */
// Key-driven playback; reads the whole buffer and hands each byte to the transmitter
`timescale 1ns/1ps

module playback_ctrl #(
  parameter int BUF_DEPTH = frame_pkg::DEFAULT_DEPTH
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              key_send_n,
  input  logic              key_abort_n,
  frame_mem_if.reader       mem,
  output logic              tx_start,
  output frame_pkg::pixel_t tx_data,
  input  logic              tx_done,
  output logic              tx_busy
);

  localparam int SYNC_N = serial_pkg::SYNC_STAGES;
  localparam int ADDR_W = $clog2(BUF_DEPTH);
  localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(BUF_DEPTH - 1);

  typedef enum logic [1:0] {PB_IDLE, PB_FETCH, PB_SEND, PB_WAIT} pb_state_t;

  pb_state_t         state;
  logic [SYNC_N:0]   send_sync;
  logic [SYNC_N:0]   abort_sync;
  logic              send_press;
  logic              abort_press;
  logic              abort_latched;
  logic [ADDR_W-1:0] byte_cnt;

  // Keys idle high and the top flop keeps the previous level
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      send_sync  <= '1;
      abort_sync <= '1;
    end else begin
      send_sync  <= {send_sync[SYNC_N-1:0], key_send_n};
      abort_sync <= {abort_sync[SYNC_N-1:0], key_abort_n};
    end
  end

  assign send_press  = send_sync[SYNC_N] & ~send_sync[SYNC_N-1];
  assign abort_press = abort_sync[SYNC_N] & ~abort_sync[SYNC_N-1];

  // ====================
  // Sequencer
  // ====================

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state         <= PB_IDLE;
      byte_cnt      <= '0;
      abort_latched <= 1'b0;
    end else begin
      case (state)
        PB_IDLE: begin
          if (send_press) begin
            byte_cnt      <= '0;
            abort_latched <= 1'b0;
            state         <= PB_FETCH;
          end
        end
        // Read data shows up the cycle after the address
        PB_FETCH: state <= PB_SEND;
        PB_SEND:  state <= PB_WAIT;
        default: begin
          if (tx_done) begin
            if (abort_latched || byte_cnt == ADDR_LAST) begin
              state <= PB_IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              state    <= PB_FETCH;
            end
          end
        end
      endcase
      // Abort only counts during playback
      if (abort_press && state != PB_IDLE) begin
        abort_latched <= 1'b1;
      end
    end
  end

  assign mem.rd_addr = byte_cnt;
  assign tx_start    = (state == PB_SEND);
  assign tx_data     = mem.rd_data;
  assign tx_busy     = (state != PB_IDLE);

endmodule

/* hdl/uart_tx.sv */
// Serial transmitter; sends one 8N1 character per start strobe and pulses done at its end
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = serial_pkg::DEFAULT_CLK_FREQ / serial_pkg::DEFAULT_BAUD
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              tx_start,
  input  frame_pkg::pixel_t tx_data,
  output logic              txd,
  output logic              tx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(serial_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(serial_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t         state;
  logic [CNT_W-1:0]  clk_cnt;
  logic [IDX_W-1:0]  bit_idx;
  frame_pkg::pixel_t shift_q;
  logic              bit_end;
  logic              shift_out;

  assign bit_end   = (clk_cnt == BIT_LAST);
  // Next data bit leaves the shifter at the end of start and every data bit but the last
  assign shift_out = bit_end &&
                     ((state == TX_START) || (state == TX_DATA && bit_idx != IDX_LAST));

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (tx_start) begin
            state <= TX_START;
            txd   <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state <= TX_DATA;
            txd   <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end && bit_idx == IDX_LAST) begin
            state <= TX_STOP;
            txd   <= 1'b1;
          end else if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            txd     <= shift_q[0];
          end
        end
        default: begin
          if (bit_end) begin
            state   <= TX_IDLE;
            tx_done <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (state == TX_IDLE && tx_start) begin
      shift_q <= tx_data;
    end else if (shift_out) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

/* hdl/frame_uart_top.sv */
// UART frame store top level; board ports, rate arithmetic and the block instances
`timescale 1ns/1ps

module frame_uart_top #(
  parameter int CLK_FREQ  = serial_pkg::DEFAULT_CLK_FREQ,
  parameter int BAUD_RATE = serial_pkg::DEFAULT_BAUD,
  parameter int BUF_DEPTH = frame_pkg::DEFAULT_DEPTH
) (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  logic                uart_rxd,
  input  logic                key_send_n,
  input  logic                key_abort_n,
  input  logic                sw_load,
  output logic                uart_txd,
  output frame_pkg::img_sel_t img_sel,
  output logic                tx_busy
);

  // Rate error of the integer divide stays small at the board clock
  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

  frame_pkg::pixel_t rx_data;
  logic              rx_valid;
  logic              tx_start;
  frame_pkg::pixel_t tx_data;
  logic              tx_done;

  frame_mem_if #(.BUF_DEPTH(BUF_DEPTH)) u_frame_mem ();

  // ====================
  // Receive path
  // ====================

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rxd      (uart_rxd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  frame_loader #(.BUF_DEPTH(BUF_DEPTH)) u_frame_loader (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .sw_load  (sw_load),
    .mem      (u_frame_mem),
    .img_sel  (img_sel)
  );

  frame_ram #(.BUF_DEPTH(BUF_DEPTH)) u_frame_ram (
    .CLOCK_50(CLOCK_50),
    .mem     (u_frame_mem)
  );

  // ====================
  // Transmit path
  // ====================

  playback_ctrl #(.BUF_DEPTH(BUF_DEPTH)) u_playback_ctrl (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .key_send_n (key_send_n),
    .key_abort_n(key_abort_n),
    .mem        (u_frame_mem),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .tx_done    (tx_done),
    .tx_busy    (tx_busy)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .txd      (uart_txd),
    .tx_done  (tx_done)
  );

endmodule

/* dv/frame_uart_chk.sv */
// Concurrent checks on the frame store top level attached to frame_uart_top with bind
`timescale 1ns/1ps

module frame_uart_chk (
  input logic                CLOCK_50,
  input logic                DLY_RST_0,
  input logic                sw_load,
  input logic                uart_txd,
  input logic                tx_busy,
  input frame_pkg::img_sel_t img_sel
);

  // Assertion failures seen so far
  int err_cnt = 0;

  // Line rests high between playbacks
  idle_line_high: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    !tx_busy |-> uart_txd)
    else begin
      err_cnt = err_cnt + 1;
      $error("uart_txd low while tx_busy is low");
    end

  busy_low_in_reset: assert property (@(posedge CLOCK_50) !DLY_RST_0 |-> !tx_busy)
    else begin
      err_cnt = err_cnt + 1;
      $error("tx_busy high during reset");
    end

  // An update at this edge would have used last cycle's switch level
  sel_held_in_load: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    $past(sw_load) |-> $stable(img_sel))
    else begin
      err_cnt = err_cnt + 1;
      $error("img_sel changed in load mode");
    end

endmodule

bind frame_uart_top frame_uart_chk u_frame_uart_chk (
  .CLOCK_50 (CLOCK_50),
  .DLY_RST_0(DLY_RST_0),
  .sw_load  (sw_load),
  .uart_txd (uart_txd),
  .tx_busy  (tx_busy),
  .img_sel  (img_sel)
);

/* dv/frame_uart_tb.sv */
// Frame store testbench; replays the case file over the serial line and keys and checks uart_txd
`timescale 1ns/1ps

module frame_uart_tb;

  localparam int CLK_FREQ     = 1_000_000;
  localparam int BAUD_RATE    = 125_000;
  localparam int BUF_DEPTH    = 8;
  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
  localparam int DATA_BITS    = serial_pkg::DATA_BITS;
  localparam int MAX_CASES    = 16;
  // Op, count, then one byte per buffer entry
  localparam int REC_W        = 2 + BUF_DEPTH;

  typedef logic [DATA_BITS-1:0] byte_t;

  logic   CLOCK_50    = 1'b0;
  logic   DLY_RST_0   = 1'b0;
  logic   uart_rxd    = 1'b1;
  logic   key_send_n  = 1'b1;
  logic   key_abort_n = 1'b1;
  logic   sw_load     = 1'b0;
  logic   uart_txd;
  byte_t  img_sel;
  logic   tx_busy;

  byte_t  case_mem [MAX_CASES*REC_W];
  byte_t  exp_bytes [BUF_DEPTH];
  byte_t  exp_sel = '0;
  byte_t  rx_q [$];
  integer seed;
  int     err_cnt = 0;
  int     pass_cases = 0;
  int     fail_cases = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  frame_uart_top #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD_RATE(BAUD_RATE),
    .BUF_DEPTH(BUF_DEPTH)
  ) i_dut (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .uart_rxd   (uart_rxd),
    .key_send_n (key_send_n),
    .key_abort_n(key_abort_n),
    .sw_load    (sw_load),
    .uart_txd   (uart_txd),
    .img_sel    (img_sel),
    .tx_busy    (tx_busy)
  );

  always #20 CLOCK_50 = ~CLOCK_50;

  always @(posedge CLOCK_50) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run went past %0d clock cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ====================
  // Transmit line decoder
  // ====================

  // Samples on the falling clock edge away from the DUT register updates
  always begin : tx_monitor
    byte_t b;
    int    k;
    @(negedge CLOCK_50);
    if (DLY_RST_0 && !uart_txd) begin
      repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
      for (k = 0; k < DATA_BITS; k++) begin
        repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
        b[k] = uart_txd;
      end
      repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
      assert (uart_txd) else begin
        $display("Stop bit missing on uart_txd at t=%0t", $time);
        err_cnt++;
      end
      rx_q.push_back(b);
    end
  end

  // ====================
  // Stimulus helpers
  // ====================

  task automatic send_char(input byte_t b);
    logic [DATA_BITS+1:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < DATA_BITS + 2; i++) begin
      uart_rxd <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge CLOCK_50);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s got %02h expected %02h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Select mode moves the expected image select and load mode leaves it alone
  task automatic send_and_check(input byte_t b, input bit is_select);
    send_char(b);
    if (is_select)
      exp_sel = b;
    @(posedge CLOCK_50);
    @(negedge CLOCK_50);
    check_byte("img_sel", img_sel, exp_sel);
    repeat (1 + $unsigned($random(seed)) % 8) @(posedge CLOCK_50);
  endtask

  task automatic press_key(input bit is_abort);
    if (is_abort)
      key_abort_n <= 1'b0;
    else
      key_send_n <= 1'b0;
    repeat (4) @(posedge CLOCK_50);
    key_send_n  <= 1'b1;
    key_abort_n <= 1'b1;
  endtask

  task automatic wait_idle();
    @(negedge CLOCK_50);
    while (tx_busy) @(negedge CLOCK_50);
    @(posedge CLOCK_50);
  endtask

  task automatic wait_rx(input int n);
    @(negedge CLOCK_50);
    while (rx_q.size() < n) @(negedge CLOCK_50);
    @(posedge CLOCK_50);
  endtask

  task automatic check_playback(input int n);
    int k;
    assert (rx_q.size() == n) else begin
      $display("Playback sent %0d bytes instead of %0d at t=%0t", rx_q.size(), n, $time);
      err_cnt++;
    end
    for (k = 0; k < n && k < rx_q.size(); k++)
      check_byte($sformatf("uart_txd byte %0d", k), rx_q[k], exp_bytes[k]);
  endtask

  task automatic report_case(input int idx, input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("case %0d %s: pass", idx, name);
      pass_cases++;
    end else begin
      $display("case %0d %s: fail with %0d errors", idx, name, err_cnt - errs_before);
      fail_cases++;
    end
  endtask

  // ====================
  // Case sequence
  // ====================

  initial begin : main_seq
    int    rec;
    int    k;
    int    op;
    int    cnt;
    int    n_chars;
    int    errs_before;
    string op_name;
    seed    = 32'hd8b5_58f1;
    n_chars = 0;
    for (k = 0; k < MAX_CASES * REC_W; k++)
      case_mem[k] = '0;
    $readmemh("dv/frame_cases.txt", case_mem);
    for (rec = 0; rec < MAX_CASES; rec++) begin
      op = case_mem[rec*REC_W];
      if (op == 1 || op == 2)
        n_chars += case_mem[rec*REC_W + 1];
      else if (op != 0)
        n_chars += BUF_DEPTH;
    end
    cycle_limit = n_chars * (DATA_BITS + 2) * CLKS_PER_BIT * 2;

    repeat (3) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
    @(posedge CLOCK_50);
    @(negedge CLOCK_50);
    check_byte("uart_txd", {7'b0, uart_txd}, 8'h01);
    check_byte("tx_busy", {7'b0, tx_busy}, 8'h00);
    check_byte("img_sel", img_sel, 8'h00);
    report_case(0, "reset", 0);
    @(posedge CLOCK_50);

    for (rec = 0; rec < MAX_CASES; rec++) begin
      op  = case_mem[rec*REC_W];
      cnt = case_mem[rec*REC_W + 1];
      if (op == 0)
        break;
      for (k = 0; k < BUF_DEPTH; k++)
        exp_bytes[k] = case_mem[rec*REC_W + 2 + k];
      errs_before = err_cnt;
      rx_q.delete();
      case (op)
        1: begin
          op_name = "select";
          sw_load <= 1'b0;
          for (k = 0; k < cnt; k++)
            send_and_check(exp_bytes[k], 1'b1);
        end
        2: begin
          // Drop the switch first so the write pointer restarts
          op_name = "load";
          sw_load <= 1'b0;
          repeat (2) @(posedge CLOCK_50);
          sw_load <= 1'b1;
          @(posedge CLOCK_50);
          for (k = 0; k < cnt; k++)
            send_and_check(exp_bytes[k], 1'b0);
        end
        3: begin
          op_name = "play";
          press_key(1'b0);
          wait_idle();
          check_playback(cnt);
        end
        4: begin
          // Abort lands inside character number cnt
          op_name = "abort";
          press_key(1'b0);
          wait_rx(cnt - 1);
          @(negedge CLOCK_50);
          while (uart_txd) @(negedge CLOCK_50);
          @(posedge CLOCK_50);
          press_key(1'b1);
          wait_idle();
          check_playback(cnt);
        end
        default: begin
          op_name = "busy-send";
          press_key(1'b0);
          wait_rx(1);
          press_key(1'b0);
          wait_idle();
          repeat (2 * CLKS_PER_BIT) @(posedge CLOCK_50);
          @(negedge CLOCK_50);
          assert (!tx_busy) else begin
            $display("Send press while busy started another playback at t=%0t", $time);
            err_cnt++;
          end
          @(posedge CLOCK_50);
          check_playback(cnt);
        end
      endcase
      report_case(rec + 1, op_name, errs_before);
    end

    $display("Summary: %0d cases passed, %0d cases failed, %0d checker failures",
             pass_cases, fail_cases, i_dut.u_frame_uart_chk.err_cnt);
    if (fail_cases == 0 && i_dut.u_frame_uart_chk.err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/frame_cases.txt */
// Columns in hex: op, count, then eight bytes (sent bytes or expected playback)
// Op 1 select, 2 load, 3 play, 4 abort inside character count, 5 send again while busy
1 03 5a 03 c7 00 00 00 00 00
2 08 11 22 33 44 55 66 77 88
3 08 11 22 33 44 55 66 77 88
2 02 a5 5a 00 00 00 00 00 00
3 08 a5 5a 33 44 55 66 77 88
4 02 a5 5a 33 44 55 66 77 88
5 08 a5 5a 33 44 55 66 77 88
1 01 e4 00 00 00 00 00 00 00
2 08 00 ff 80 01 7e 81 c3 3c
3 08 00 ff 80 01 7e 81 c3 3c
4 01 00 ff 80 01 7e 81 c3 3c
1 02 9b 26 00 00 00 00 00 00
0 00 00 00 00 00 00 00 00 00

/* frame_uart.f */
hdl/serial_pkg.sv
hdl/frame_pkg.sv
hdl/frame_mem_if.sv
hdl/uart_rx.sv
hdl/frame_loader.sv
hdl/frame_ram.sv
hdl/playback_ctrl.sv
hdl/uart_tx.sv
hdl/frame_uart_top.sv
dv/frame_uart_chk.sv
dv/frame_uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the frame store simulation with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=frame_uart_sim
LOG_FILE=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module frame_uart_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f frame_uart.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Keep counting checker errors instead of stopping at the first one
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
